// File: cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [7:0] memAddrT;
	typedef logic [3:0] tagT;

	localparam int memWords = 256;
	localparam int cacheLines = 16;
	localparam int memLatency = 2;
	localparam wordT resetPc = 32'h0000_0000;
	// Fetch address used while the core is halted, outside main memory
	localparam wordT parkPc = 32'hFFFF_FFFC;
	// addi x0, x0, 0
	localparam wordT nopInstr = 32'h0000_0013;

	localparam logic [6:0] opRegister = 7'b0110011;
	localparam logic [6:0] opImmediate = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [6:0] f7Sub = 7'b0100000;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOpT;
	typedef enum logic [1:0] {cacheIdle, cacheWait, cacheFill} cacheStateT;
	typedef enum logic [1:0] {arbIdle, arbInstr, arbData} arbStateT;

endpackage

// File: regFile.sv
`timescale 1ns/1ps
module regFile (
	input logic clock,
	input logic reset,
	input cpuPkg::regAddrT readAddressA,
	input cpuPkg::regAddrT readAddressB,
	input cpuPkg::regAddrT writeAddress,
	input logic writeEnable,
	input cpuPkg::wordT writeData,
	output cpuPkg::wordT readDataA,
	output cpuPkg::wordT readDataB
);
	import cpuPkg::*;

	wordT regs [32];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddress != '0) begin
			regs[writeAddress] <= writeData;
		end
	end

	// Same-cycle write shows through to the readers
	assign readDataA = (readAddressA == '0) ? '0 :
		(writeEnable && writeAddress == readAddressA) ? writeData : regs[readAddressA];
	assign readDataB = (readAddressB == '0) ? '0 :
		(writeEnable && writeAddress == readAddressB) ? writeData : regs[readAddressB];

endmodule

// File: pipelineCore.sv
`timescale 1ns/1ps
module pipelineCore (
	input logic clock,
	input logic reset,
	input logic run,
	input cpuPkg::wordT fetchData,
	input logic instrStall,
	input cpuPkg::wordT dataReadData,
	input logic dataStall,
	output cpuPkg::wordT fetchAddress,
	output logic dataRead,
	output logic dataWrite,
	output cpuPkg::wordT dataAddress,
	output cpuPkg::wordT dataWriteData,
	output logic commitValid,
	output cpuPkg::regAddrT commitRegister,
	output cpuPkg::wordT commitData
);
	import cpuPkg::*;

	wordT pc, ifidPc, ifidInstr;
	wordT idexPc, idexA, idexB, idexImm;
	regAddrT idexRs1, idexRs2, idexRd;
	aluOpT idexAluOp;
	logic idexRegWrite, idexMemRead, idexMemWrite, idexBranch, idexJump, idexUseImm;
	wordT exmemAlu, exmemStoreData;
	regAddrT exmemRd;
	logic exmemRegWrite, exmemMemRead, exmemMemWrite;
	wordT memwbData;
	regAddrT memwbRd;
	logic memwbRegWrite;

	logic [6:0] opcode;
	regAddrT rs1, rs2, rd;
	wordT immI, immS, immB, immJ, imm, readA, readB;
	logic regWrite, useImm, loadUse, advance, taken;
	aluOpT aluOp;
	wordT fwdA, fwdB, aluB, aluResult, target;

	// Whole pipeline freezes on any cache miss
	assign advance = run && !instrStall && !dataStall;
	assign fetchAddress = run ? pc : parkPc;

	// Decode
	assign opcode = ifidInstr[6:0];
	assign rd = ifidInstr[11:7];
	assign rs1 = ifidInstr[19:15];
	assign rs2 = ifidInstr[24:20];
	assign immI = {{20{ifidInstr[31]}}, ifidInstr[31:20]};
	assign immS = {{20{ifidInstr[31]}}, ifidInstr[31:25], ifidInstr[11:7]};
	assign immB = {{19{ifidInstr[31]}}, ifidInstr[31], ifidInstr[7], ifidInstr[30:25],
		ifidInstr[11:8], 1'b0};
	assign immJ = {{11{ifidInstr[31]}}, ifidInstr[31], ifidInstr[19:12], ifidInstr[20],
		ifidInstr[30:21], 1'b0};
	assign imm = (opcode == opStore) ? immS : (opcode == opBranch) ? immB :
		(opcode == opJal) ? immJ : immI;
	assign regWrite = opcode inside {opRegister, opImmediate, opLoad, opJal};
	assign useImm = opcode inside {opImmediate, opLoad, opStore};

	always_comb begin
		aluOp = aluAdd;
		if (opcode == opRegister) begin
			case (ifidInstr[14:12])
				f3AddSub: aluOp = (ifidInstr[31:25] == f7Sub) ? aluSub : aluAdd;
				f3Slt: aluOp = aluSlt;
				f3Xor: aluOp = aluXor;
				f3Or: aluOp = aluOr;
				f3And: aluOp = aluAnd;
				default: aluOp = aluAdd;
			endcase
		end
	end

	regFile registers (
		.clock(clock),
		.reset(reset),
		.readAddressA(rs1),
		.readAddressB(rs2),
		.writeAddress(memwbRd),
		.writeEnable(memwbRegWrite && advance),
		.writeData(memwbData),
		.readDataA(readA),
		.readDataB(readB)
	);

	// Load in EX feeding the instruction in ID
	assign loadUse = idexMemRead && idexRd != '0 && (idexRd == rs1 || idexRd == rs2);

	// Forwarding, EX/MEM takes priority over MEM/WB
	assign fwdA = (exmemRegWrite && exmemRd != '0 && exmemRd == idexRs1) ? exmemAlu :
		(memwbRegWrite && memwbRd != '0 && memwbRd == idexRs1) ? memwbData : idexA;
	assign fwdB = (exmemRegWrite && exmemRd != '0 && exmemRd == idexRs2) ? exmemAlu :
		(memwbRegWrite && memwbRd != '0 && memwbRd == idexRs2) ? memwbData : idexB;
	assign aluB = idexUseImm ? idexImm : fwdB;
	assign target = idexPc + idexImm;
	assign taken = idexJump || (idexBranch && fwdA == fwdB);

	always_comb begin
		case (idexAluOp)
			aluSub: aluResult = fwdA - aluB;
			aluAnd: aluResult = fwdA & aluB;
			aluOr: aluResult = fwdA | aluB;
			aluXor: aluResult = fwdA ^ aluB;
			aluSlt: aluResult = {31'b0, $signed(fwdA) < $signed(aluB)};
			default: aluResult = fwdA + aluB;
		endcase
		// jal links PC+4
		if (idexJump) begin
			aluResult = idexPc + 32'd4;
		end
	end

	// Control state: PC, IF/ID instruction and stage valid bits
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= resetPc;
			ifidInstr <= nopInstr;
			{idexRegWrite, idexMemRead, idexMemWrite, idexBranch, idexJump} <= '0;
			{exmemRegWrite, exmemMemRead, exmemMemWrite} <= '0;
			memwbRegWrite <= 1'b0;
		end else if (advance) begin
			if (taken) begin
				pc <= target;
				ifidInstr <= nopInstr;
			end else if (!loadUse) begin
				pc <= pc + 32'd4;
				ifidInstr <= fetchData;
			end
			if (taken || loadUse) begin
				{idexRegWrite, idexMemRead, idexMemWrite, idexBranch, idexJump} <= '0;
			end else begin
				idexRegWrite <= regWrite;
				idexMemRead <= opcode == opLoad;
				idexMemWrite <= opcode == opStore;
				idexBranch <= opcode == opBranch;
				idexJump <= opcode == opJal;
			end
			exmemRegWrite <= idexRegWrite;
			exmemMemRead <= idexMemRead;
			exmemMemWrite <= idexMemWrite;
			memwbRegWrite <= exmemRegWrite;
		end
	end

	// Payload registers
	always_ff @(posedge clock) begin
		if (advance) begin
			if (!taken && !loadUse) begin
				ifidPc <= pc;
			end
			idexPc <= ifidPc;
			idexA <= readA;
			idexB <= readB;
			idexImm <= imm;
			idexRs1 <= rs1;
			idexRs2 <= rs2;
			idexRd <= rd;
			idexAluOp <= aluOp;
			idexUseImm <= useImm;
			exmemAlu <= aluResult;
			exmemStoreData <= fwdB;
			exmemRd <= idexRd;
			memwbData <= exmemMemRead ? dataReadData : exmemAlu;
			memwbRd <= exmemRd;
		end
	end

	assign dataRead = exmemMemRead;
	assign dataWrite = exmemMemWrite;
	assign dataAddress = exmemAlu;
	assign dataWriteData = exmemStoreData;

	// Retires when WB hands off, never for x0
	assign commitValid = advance && memwbRegWrite && memwbRd != '0;
	assign commitRegister = memwbRd;
	assign commitData = memwbData;

endmodule

// File: instrCache.sv
`timescale 1ns/1ps
module instrCache (
	input logic clock,
	input logic reset,
	input cpuPkg::wordT fetchAddress,
	input logic instrMemDone,
	input cpuPkg::wordT memReadData,
	output cpuPkg::wordT fetchData,
	output logic instrStall,
	output logic instrMemRequest,
	output cpuPkg::memAddrT instrMemAddress
);
	import cpuPkg::*;

	logic [cacheLines-1:0] valid;
	tagT tags [cacheLines];
	wordT lines [cacheLines];
	cacheStateT state;
	logic [3:0] index;
	logic inMemory, hit;

	assign index = fetchAddress[5:2];
	assign inMemory = fetchAddress[31:10] == '0;
	assign hit = valid[index] && tags[index] == fetchAddress[9:6];
	assign instrMemAddress = fetchAddress[9:2];

	// Parked fetches outside memory see a NOP and never stall
	assign fetchData = inMemory ? lines[index] : nopInstr;
	assign instrStall = inMemory && !hit;
	assign instrMemRequest = (state == cacheIdle && instrStall) || state == cacheWait;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= cacheIdle;
			valid <= '0;
		end else begin
			case (state)
				cacheIdle: if (instrStall) state <= cacheWait;
				cacheWait: begin
					if (instrMemDone) begin
						valid[index] <= 1'b1;
						state <= cacheFill;
					end
				end
				default: state <= cacheIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == cacheWait && instrMemDone) begin
			tags[index] <= fetchAddress[9:6];
			lines[index] <= memReadData;
		end
	end

endmodule

// File: dataCache.sv
`timescale 1ns/1ps
module dataCache (
	input logic clock,
	input logic reset,
	input logic dataRead,
	input logic dataWrite,
	input cpuPkg::wordT dataAddress,
	input cpuPkg::wordT dataWriteData,
	input logic dataMemDone,
	input cpuPkg::wordT memReadData,
	output cpuPkg::wordT dataReadData,
	output logic dataStall,
	output logic dataMemRequest,
	output logic dataMemWrite,
	output cpuPkg::memAddrT dataMemAddress,
	output cpuPkg::wordT dataMemWriteData
);
	import cpuPkg::*;

	logic [cacheLines-1:0] valid;
	tagT tags [cacheLines];
	wordT lines [cacheLines];
	cacheStateT state;
	logic [3:0] index;
	logic hit, needMemory;

	assign index = dataAddress[5:2];
	assign hit = valid[index] && tags[index] == dataAddress[9:6];
	// Every store goes through to memory
	assign needMemory = (dataRead && !hit) || dataWrite;

	// Fill is the one cycle where a finished access lets the core move on
	assign dataStall = state != cacheFill && needMemory;
	assign dataReadData = lines[index];
	assign dataMemRequest = (state == cacheIdle && needMemory) || state == cacheWait;
	assign dataMemWrite = dataWrite;
	assign dataMemAddress = dataAddress[9:2];
	assign dataMemWriteData = dataWriteData;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= cacheIdle;
			valid <= '0;
		end else begin
			case (state)
				cacheIdle: if (needMemory) state <= cacheWait;
				cacheWait: begin
					if (dataMemDone) begin
						if (!dataWrite) valid[index] <= 1'b1;
						state <= cacheFill;
					end
				end
				default: state <= cacheIdle;
			endcase
		end
	end

	// Read miss fills the line, store updates it only on a hit
	always_ff @(posedge clock) begin
		if (state == cacheWait && dataMemDone) begin
			if (!dataWrite) begin
				tags[index] <= dataAddress[9:6];
				lines[index] <= memReadData;
			end else if (hit) begin
				lines[index] <= dataWriteData;
			end
		end
	end

endmodule

// File: memArbiter.sv
`timescale 1ns/1ps
module memArbiter (
	input logic clock,
	input logic reset,
	input logic instrMemRequest,
	input cpuPkg::memAddrT instrMemAddress,
	input logic dataMemRequest,
	input logic dataMemWrite,
	input cpuPkg::memAddrT dataMemAddress,
	input cpuPkg::wordT dataMemWriteData,
	input logic memReady,
	output logic memRequest,
	output logic memWrite,
	output cpuPkg::memAddrT memAddress,
	output cpuPkg::wordT memWriteData,
	output logic instrMemDone,
	output logic dataMemDone
);
	import cpuPkg::*;

	arbStateT state;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= arbIdle;
		end else begin
			case (state)
				// Data cache wins a tie
				arbIdle: begin
					if (dataMemRequest) state <= arbData;
					else if (instrMemRequest) state <= arbInstr;
				end
				default: if (memReady) state <= arbIdle;
			endcase
		end
	end

	assign memRequest = (state == arbInstr && instrMemRequest) ||
		(state == arbData && dataMemRequest);
	assign memWrite = state == arbData && dataMemWrite;
	assign memAddress = (state == arbData) ? dataMemAddress : instrMemAddress;
	assign memWriteData = dataMemWriteData;
	assign instrMemDone = state == arbInstr && memReady;
	assign dataMemDone = state == arbData && memReady;

endmodule

// File: mainMemory.sv
`timescale 1ns/1ps
module mainMemory (
	input logic clock,
	input logic reset,
	input logic memRequest,
	input logic memWrite,
	input cpuPkg::memAddrT memAddress,
	input cpuPkg::wordT memWriteData,
	input logic loadEnable,
	input cpuPkg::memAddrT loadAddress,
	input cpuPkg::wordT loadData,
	output cpuPkg::wordT memReadData,
	output logic memReady
);
	import cpuPkg::*;

	wordT mem [memWords];
	logic busy, pendWrite, accept;
	logic [1:0] count;
	memAddrT pendAddress;
	wordT pendData;

	// No new request in the ready cycle, the owner drops it at that edge
	assign accept = memRequest && !busy && !memReady;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
			count <= '0;
			memReady <= 1'b0;
		end else begin
			memReady <= 1'b0;
			if (busy) begin
				count <= count - 2'd1;
				if (count == 2'd1) begin
					busy <= 1'b0;
					memReady <= 1'b1;
				end
			end else if (accept) begin
				busy <= 1'b1;
				count <= 2'(memLatency);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			pendWrite <= memWrite;
			pendAddress <= memAddress;
			pendData <= memWriteData;
		end
		if (busy && count == 2'd1) begin
			if (pendWrite) mem[pendAddress] <= pendData;
			else memReadData <= mem[pendAddress];
		end
		// Program load, only used while the core is halted
		if (loadEnable) mem[loadAddress] <= loadData;
	end

endmodule

// File: cpuTop.sv
`timescale 1ns/1ps
module cpuTop (
	input logic clock,
	input logic reset,
	input logic run,
	input logic loadEnable,
	input cpuPkg::memAddrT loadAddress,
	input cpuPkg::wordT loadData,
	output logic commitValid,
	output cpuPkg::regAddrT commitRegister,
	output cpuPkg::wordT commitData
);
	import cpuPkg::*;

	wordT fetchAddress, fetchData, dataAddress, dataWriteData, dataReadData;
	wordT memReadData, dataMemWriteData, memWriteData;
	memAddrT instrMemAddress, dataMemAddress, memAddress;
	logic instrStall, dataStall, dataRead, dataWrite;
	logic instrMemRequest, instrMemDone, dataMemRequest, dataMemWrite, dataMemDone;
	logic memRequest, memWrite, memReady;

	pipelineCore core (.clock(clock), .reset(reset), .run(run), .fetchData(fetchData),
		.instrStall(instrStall), .dataReadData(dataReadData), .dataStall(dataStall),
		.fetchAddress(fetchAddress), .dataRead(dataRead), .dataWrite(dataWrite),
		.dataAddress(dataAddress), .dataWriteData(dataWriteData), .commitValid(commitValid),
		.commitRegister(commitRegister), .commitData(commitData));

	instrCache iCache (.clock(clock), .reset(reset), .fetchAddress(fetchAddress),
		.instrMemDone(instrMemDone), .memReadData(memReadData), .fetchData(fetchData),
		.instrStall(instrStall), .instrMemRequest(instrMemRequest),
		.instrMemAddress(instrMemAddress));

	dataCache dCache (.clock(clock), .reset(reset), .dataRead(dataRead),
		.dataWrite(dataWrite), .dataAddress(dataAddress), .dataWriteData(dataWriteData),
		.dataMemDone(dataMemDone), .memReadData(memReadData), .dataReadData(dataReadData),
		.dataStall(dataStall), .dataMemRequest(dataMemRequest), .dataMemWrite(dataMemWrite),
		.dataMemAddress(dataMemAddress), .dataMemWriteData(dataMemWriteData));

	memArbiter arbiter (.clock(clock), .reset(reset), .instrMemRequest(instrMemRequest),
		.instrMemAddress(instrMemAddress), .dataMemRequest(dataMemRequest),
		.dataMemWrite(dataMemWrite), .dataMemAddress(dataMemAddress),
		.dataMemWriteData(dataMemWriteData), .memReady(memReady), .memRequest(memRequest),
		.memWrite(memWrite), .memAddress(memAddress), .memWriteData(memWriteData),
		.instrMemDone(instrMemDone), .dataMemDone(dataMemDone));

	mainMemory memory (.clock(clock), .reset(reset), .memRequest(memRequest),
		.memWrite(memWrite), .memAddress(memAddress), .memWriteData(memWriteData),
		.loadEnable(loadEnable), .loadAddress(loadAddress), .loadData(loadData),
		.memReadData(memReadData), .memReady(memReady));

endmodule

// File: cpuProperties.sv
`timescale 1ns/1ps
module cpuProperties (
	input logic clock,
	input logic reset,
	input logic instrMemRequest,
	input logic dataMemRequest,
	input logic memRequest,
	input logic memWrite,
	input logic memReady,
	input logic instrMemDone,
	input logic dataMemDone,
	input logic commitValid
);

	// Done pulse reaches only the cache that still holds its request
	assert property (@(posedge clock) disable iff (!reset)
		instrMemDone |-> instrMemRequest)
		else $error("instruction done pulse without a pending request");

	assert property (@(posedge clock) disable iff (!reset)
		dataMemDone |-> dataMemRequest)
		else $error("data done pulse without a pending request");

	assert property (@(posedge clock) disable iff (!reset)
		memWrite |-> dataMemRequest)
		else $error("memory write not owned by the data cache");

	// Grant stays until the memory answers
	assert property (@(posedge clock) disable iff (!reset)
		(memRequest && !memReady) |=> (memRequest && $stable(memWrite)))
		else $error("grant dropped before memReady");

	// No retirement while held in reset
	assert property (@(posedge clock) !reset |-> !commitValid)
		else $error("commit while in reset");

endmodule

bind cpuTop cpuProperties props (
	.clock(clock),
	.reset(reset),
	.instrMemRequest(instrMemRequest),
	.dataMemRequest(dataMemRequest),
	.memRequest(memRequest),
	.memWrite(memWrite),
	.memReady(memReady),
	.instrMemDone(instrMemDone),
	.dataMemDone(dataMemDone),
	.commitValid(commitValid)
);

// File: cpuTb.sv
`timescale 1ns/1ps
module cpuTb;
	import cpuPkg::*;

	localparam int timeoutCycles = 6000;
	localparam int quietCycles = 40;
	// add, sub, and, or, xor, slt
	localparam logic [2:0] aluFunct3 [6] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};

	logic clock;
	logic reset;
	logic run;
	logic loadEnable;
	memAddrT loadAddress;
	wordT loadData;
	logic commitValid;
	regAddrT commitRegister;
	wordT commitData;

	wordT image [memWords];
	regAddrT expRegister [$];
	wordT expData [$];
	int commitCount;
	int testErrors;
	int passCount;
	int failCount;
	logic checking;
	string testName;

	cpuTop DUT (
		.clock(clock),
		.reset(reset),
		.run(run),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.commitValid(commitValid),
		.commitRegister(commitRegister),
		.commitData(commitData)
	);

	always #20 clock = ~clock;

	function automatic wordT encodeR(input int kind, input regAddrT rd, input regAddrT rs1,
			input regAddrT rs2);
		logic [6:0] f7;
		f7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
		return {f7, rs2, rs1, aluFunct3[kind], rd, opRegister};
	endfunction

	function automatic wordT encodeI(input logic [6:0] op, input logic [2:0] f3,
			input regAddrT rd, input regAddrT rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic wordT encodeS(input regAddrT rs1, input regAddrT rs2,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	function automatic wordT encodeB(input regAddrT rs1, input regAddrT rs2,
			input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic wordT encodeJ(input regAddrT rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	function automatic wordT aluModel(input logic [2:0] f3, input logic sub, input wordT a,
			input wordT b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			3'b111: return a & b;
			default: return a + b;
		endcase
	endfunction

	// Random program on x0..x7, ending in a beq self-loop
	task automatic makeProgram(input int length, input int memPercent, input int ctrlPercent);
		int roll;
		int skip;
		regAddrT rd;
		regAddrT rs1;
		regAddrT rs2;
		logic [11:0] offset;
		for (int w = 0; w < memWords; w++) begin
			image[w] = {8'(w), ~8'(w), 8'(w) ^ 8'h5a, 8'h13};
		end
		for (int i = 0; i < length - 1; i++) begin
			rd = regAddrT'($urandom_range(7));
			rs1 = regAddrT'($urandom_range(7));
			rs2 = regAddrT'($urandom_range(7));
			// Data words 128 to 143
			offset = 12'(512 + 4 * $urandom_range(15));
			roll = $urandom_range(99);
			skip = $urandom_range(1, 3);
			if (i + skip > length - 1)
				skip = length - 1 - i;
			if (roll < memPercent) begin
				if ($urandom_range(1))
					image[i] = encodeI(opLoad, 3'b010, rd, 5'd0, offset);
				else
					image[i] = encodeS(5'd0, rs2, offset);
			end else if (roll < memPercent + ctrlPercent) begin
				if ($urandom_range(1))
					image[i] = encodeJ(rd, 21'(4 * skip));
				else
					image[i] = encodeB(rs1, $urandom_range(1) ? rs1 : rs2, 13'(4 * skip));
			end else if (roll < memPercent + ctrlPercent + 25) begin
				image[i] = encodeI(opImmediate, 3'b000, rd, rs1, 12'($urandom_range(4095)));
			end else begin
				image[i] = encodeR($urandom_range(5), rd, rs1, rs2);
			end
		end
		image[length - 1] = encodeB(5'd0, 5'd0, 13'd0);
	endtask

	// Instruction-set model, builds the expected commit stream
	task automatic runModel(input int length);
		wordT regs [32];
		wordT dmem [memWords];
		wordT instr;
		wordT a;
		wordT b;
		wordT pc;
		wordT nextPc;
		wordT result;
		wordT immI;
		wordT immS;
		wordT immB;
		wordT immJ;
		regAddrT rd;
		logic write;
		int steps;
		foreach (regs[r])
			regs[r] = '0;
		dmem = image;
		expRegister.delete();
		expData.delete();
		pc = 32'd0;
		steps = 0;
		while (pc != 32'(4 * (length - 1)) && steps < 1000) begin
			instr = dmem[pc[9:2]];
			rd = instr[11:7];
			a = regs[instr[19:15]];
			b = regs[instr[24:20]];
			immI = {{20{instr[31]}}, instr[31:20]};
			immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			nextPc = pc + 32'd4;
			write = 1'b0;
			result = '0;
			case (instr[6:0])
				opRegister: begin
					result = aluModel(instr[14:12], instr[30], a, b);
					write = 1'b1;
				end
				opImmediate: begin
					result = a + immI;
					write = 1'b1;
				end
				opLoad: begin
					result = dmem[8'((a + immI) >> 2)];
					write = 1'b1;
				end
				opStore:
					dmem[8'((a + immS) >> 2)] = b;
				opBranch:
					if (a == b)
						nextPc = pc + immB;
				opJal: begin
					result = pc + 32'd4;
					write = 1'b1;
					nextPc = pc + immJ;
				end
				default: ;
			endcase
			if (write && rd != 5'd0) begin
				regs[rd] = result;
				expRegister.push_back(rd);
				expData.push_back(result);
			end
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic applyReset();
		@(negedge clock);
		run = 1'b0;
		reset = 1'b0;
		for (int c = 0; c < 5; c++)
			@(negedge clock);
		reset = 1'b1;
	endtask

	task automatic loadImage();
		for (int w = 0; w < memWords; w++) begin
			@(negedge clock);
			loadEnable = 1'b1;
			loadAddress = memAddrT'(w);
			loadData = image[w];
		end
		@(negedge clock);
		loadEnable = 1'b0;
	endtask

	task automatic finishTest(input int checked);
		if (testErrors == 0) begin
			passCount++;
			$display("%s: passed, %0d checks", testName, checked);
		end else begin
			failCount++;
			$display("%s: failed, %0d errors", testName, testErrors);
		end
	endtask

	task automatic runProgram(input string name, input int length, input int memPercent,
			input int ctrlPercent);
		int expected;
		int cycles;
		testName = name;
		testErrors = 0;
		makeProgram(length, memPercent, ctrlPercent);
		runModel(length);
		expected = expRegister.size();
		applyReset();
		loadImage();
		commitCount = 0;
		checking = 1'b1;
		@(negedge clock);
		run = 1'b1;
		cycles = 0;
		while (commitCount < expected && cycles < timeoutCycles) begin
			@(negedge clock);
			cycles++;
		end
		if (commitCount < expected) begin
			$display("%s: timed out after %0d cycles with %0d of %0d commits", name, cycles,
				commitCount, expected);
			testErrors++;
		end
		// Self-loop keeps running, flushed fetches must not commit
		for (int c = 0; c < quietCycles; c++)
			@(negedge clock);
		run = 1'b0;
		checking = 1'b0;
		finishTest(expected);
	endtask

	// Commit checker
	always @(posedge clock) begin
		if ((!reset || !run) && commitValid) begin
			$display("%s: commitValid high while the core is halted", testName);
			testErrors++;
		end else if (checking && commitValid) begin
			if (expRegister.size() == 0) begin
				$display("%s: unexpected extra commit to x%0d", testName, commitRegister);
				testErrors++;
			end else begin
				if (commitRegister !== expRegister[0] || commitData !== expData[0]) begin
					$display("** Error %s: commit %0d expected x%0d = %h, actual x%0d = %h",
						testName, commitCount, expRegister[0], expData[0], commitRegister,
						commitData);
					testErrors++;
				end
				void'(expRegister.pop_front());
				void'(expData.pop_front());
			end
			commitCount++;
		end
	end

	initial begin
		void'($urandom(32'hfa6b));
		clock = 1'b0;
		reset = 1'b0;
		run = 1'b0;
		loadEnable = 1'b0;
		loadAddress = '0;
		loadData = '0;
		checking = 1'b0;
		commitCount = 0;
		passCount = 0;
		failCount = 0;

		// Halted core, the checker watches commitValid
		testName = "reset";
		testErrors = 0;
		applyReset();
		for (int c = 0; c < 20; c++)
			@(negedge clock);
		finishTest(25);

		runProgram("aluSequences", 32, 0, 0);
		runProgram("loadStore", 32, 50, 0);
		runProgram("controlFlow", 32, 10, 35);
		runProgram("contention", 40, 60, 10);
		runProgram("reload", 36, 30, 15);

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: compile.f
cpuPkg.sv
regFile.sv
pipelineCore.sv
instrCache.sv
dataCache.sv
memArbiter.sv
mainMemory.sv
cpuTop.sv
cpuProperties.sv
cpuTb.sv
